/* Makefile */
# Verilator build and run of the interrupt controller testbench

TOP := ipic_tb

.PHONY: build run clean

build:
	verilator --binary --timing --assert -f ipic_top.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/ipic_apb_regs.sv */
/*
 * APB register side of the interrupt controller
 * Holds IDX and line configuration, decodes write strobes, answers reads
 */

`timescale 1ns/1ps

`include "ipic_consts.svh"

module ipic_apb_regs
    import ipic_reg_pkg::*;
    import ipic_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // APB slave, zero wait states
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    // Status from the interrupt side
    input  irq_vec_t  ipr,
    input  ipic_svc_t svc,
    // Configuration and strobes
    output ipic_cfg_t cfg,
    output ipic_ctl_t ctl
);

    logic      wr_acc;  // Write access phase
    logic      rd_acc;  // Read access phase
    ipic_reg_e reg_sel; // Addressed register
    irq_idx_t  idx;     // Line selector

    assign wr_acc  = psel & penable & pwrite;
    assign rd_acc  = psel & penable & ~pwrite;
    assign reg_sel = ipic_reg_e'(paddr[REG_OFF_LSB +: 3]); // Byte lanes ignored

    // --------------------
    // Configuration
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
            cfg <= '0;
        end else if (wr_acc) begin
            case (reg_sel)
                REG_IDX: begin
                    idx <= pwdata[$bits(irq_idx_t)-1:0];
                end
                REG_ICSR: begin // Only the selected line changes
                    cfg.ie[idx]  <= pwdata[`IPIC_ICSR_IE];
                    cfg.im[idx]  <= pwdata[`IPIC_ICSR_IM];
                    cfg.inv[idx] <= pwdata[`IPIC_ICSR_INV];
                end
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // Write strobes
    // --------------------
    always_comb begin
        ctl = '0;
        if (wr_acc) begin
            case (reg_sel)
                REG_IPR: begin
                    ctl.clr = pwdata[`IPIC_LINES-1:0]; // Write 1 to clear
                end
                REG_ICSR: begin
                    ctl.clr[idx] = pwdata[`IPIC_ICSR_IP];
                end
                REG_SOI: begin
                    ctl.soi = 1'b1;
                end
                REG_EOI: begin
                    ctl.eoi = 1'b1;
                end
                default: begin // Read-only registers ignore writes
                end
            endcase
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        prdata = '0; // Zero outside the access phase
        if (rd_acc) begin
            case (reg_sel)
                REG_CISV: prdata = apb_data_t'(svc.cisv);
                REG_CICSR_RSVD: prdata = '0;
                REG_IPR: prdata = apb_data_t'(ipr);
                REG_ISVR: prdata = apb_data_t'(svc.isvr);
                REG_EOI, REG_SOI: prdata = '0; // Strobes only
                REG_IDX: prdata = apb_data_t'(idx);
                REG_ICSR: begin
                    prdata[`IPIC_ICSR_IP]  = ipr[idx];
                    prdata[`IPIC_ICSR_IE]  = cfg.ie[idx];
                    prdata[`IPIC_ICSR_IM]  = cfg.im[idx];
                    prdata[`IPIC_ICSR_INV] = cfg.inv[idx];
                    prdata[`IPIC_ICSR_IS]  = svc.isvr[idx];
                    prdata[`IPIC_ICSR_LN_LSB +: $bits(irq_idx_t)] = idx; // Line number
                end
                default: prdata = '0;
            endcase
        end
    end

endmodule

/* hw/ipic_consts.svh */
/*
 * Interrupt controller constants
 * Line count, APB widths, void vector and ICSR bit layout
 */

`ifndef IPIC_CONSTS_SVH
`define IPIC_CONSTS_SVH

// --------------------
// Sizes
// --------------------
`define IPIC_LINES        8     // External interrupt lines
`define IPIC_VECT_W       4     // Vector number, void included
`define IPIC_VOID_VECT    8     // Nothing in service
`define IPIC_ADDR_W       5     // APB byte address
`define IPIC_DATA_W       32    // APB data bus

// --------------------
// ICSR layout
// --------------------
`define IPIC_ICSR_IP      0     // Pending
`define IPIC_ICSR_IE      1     // Enable
`define IPIC_ICSR_IM      2     // Mode, 1 = edge
`define IPIC_ICSR_INV     3     // Line inversion
`define IPIC_ICSR_IS      4     // In service
`define IPIC_ICSR_LN_LSB  12    // Line number field, 3 bits

`endif

/* hw/ipic_irq_pkg.sv */
/*
 * Interrupt side types
 * Line vectors, vector numbers and the structs between blocks
 */

`include "ipic_consts.svh"

package ipic_irq_pkg;

    typedef logic [`IPIC_LINES-1:0]         irq_vec_t;  // One bit per line
    typedef logic [$clog2(`IPIC_LINES)-1:0] irq_idx_t;  // Line index
    typedef logic [`IPIC_VECT_W-1:0]        irq_num_t;  // Vector number or void

    // Per-line configuration
    typedef struct packed {
        irq_vec_t ie;   // Enable
        irq_vec_t im;   // 1 = edge, 0 = level
        irq_vec_t inv;  // Invert line
    } ipic_cfg_t;

    // Register write strobes, one cycle wide
    typedef struct packed {
        irq_vec_t clr;  // Pending clears
        logic     soi;
        logic     eoi;
    } ipic_ctl_t;

    // Service state for readback
    typedef struct packed {
        irq_vec_t isvr; // Lines in service
        irq_num_t cisv; // Current vector
    } ipic_svc_t;

endpackage

/* hw/ipic_pending.sv */
/*
 * Pending register of the interrupt controller
 * Inversion, edge detection and the level or edge rule per line
 */

`timescale 1ns/1ps

`include "ipic_consts.svh"

module ipic_pending
    import ipic_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  irq_vec_t  irq_lines,  // Synchronous to clk
    input  ipic_cfg_t cfg,
    input  ipic_ctl_t ctl,
    input  irq_vec_t  taken,      // Line moved into service
    output irq_vec_t  ipr
);

    irq_vec_t line_q;   // Lines one cycle ago
    irq_vec_t lvl;      // Active level after inversion
    irq_vec_t edge_det; // Change towards the active level
    irq_vec_t clr_all;  // Register clears and SOI clears
    irq_vec_t ipr_d;

    assign lvl      = irq_lines ^ cfg.inv;
    assign edge_det = (irq_lines ^ line_q) & lvl;
    assign clr_all  = ctl.clr | taken;

    // --------------------
    // Next pending value
    // --------------------
    always_comb begin
        for (int i = 0; i < `IPIC_LINES; i++) begin
            if (!cfg.im[i]) begin
                // Level mode follows the line so a clear cannot drop an active level
                ipr_d[i] = lvl[i];
            end else begin
                ipr_d[i] = edge_det[i] | (ipr[i] & ~clr_all[i]); // New edge beats clear
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_q <= '0;
            ipr    <= '0;
        end else begin
            line_q <= irq_lines;
            ipr    <= ipr_d;
        end
    end

endmodule

/* hw/ipic_reg_pkg.sv */
/*
 * Register map of the interrupt controller
 * APB bus field types and register word offsets
 */

`include "ipic_consts.svh"

package ipic_reg_pkg;

    // APB fields
    typedef logic [`IPIC_ADDR_W-1:0] apb_addr_t;  // Byte address
    typedef logic [`IPIC_DATA_W-1:0] apb_data_t;  // Read and write data

    // Word select starts above the byte lanes
    localparam int REG_OFF_LSB = 2;

    // Register word offsets, paddr[4:2]
    typedef enum logic [2:0] {
        REG_CISV       = 3'd0,  // Current vector, read only
        REG_CICSR_RSVD = 3'd1,  // Reserved, reads zero
        REG_IPR        = 3'd2,  // Pending, write 1 to clear
        REG_ISVR       = 3'd3,  // In service, read only
        REG_EOI        = 3'd4,  // End of interrupt strobe
        REG_SOI        = 3'd5,  // Start of interrupt strobe
        REG_IDX        = 3'd6,  // Line selector
        REG_ICSR       = 3'd7   // Control and status of line IDX
    } ipic_reg_e;

endpackage

/* hw/ipic_service.sv */
/*
 * Service tracking of the interrupt controller
 * Priority search, nested ISVR and CISV, SOI and EOI, and irq_req
 */

`timescale 1ns/1ps

`include "ipic_consts.svh"

module ipic_service
    import ipic_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  irq_vec_t  ipr,
    input  ipic_cfg_t cfg,
    input  ipic_ctl_t ctl,
    output ipic_svc_t svc,
    output irq_vec_t  taken,   // One-hot, pulses with an accepted SOI
    output logic      irq_req  // Request beats the one in service
);

    localparam irq_num_t VOID = irq_num_t'(`IPIC_VOID_VECT);

    // Lowest set index wins, void when empty
    function automatic irq_num_t find_lowest(input irq_vec_t vec);
        irq_num_t num;
        num = VOID;
        for (int i = `IPIC_LINES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                num = irq_num_t'(i);
            end
        end
        return num;
    endfunction

    irq_vec_t isvr;
    irq_num_t cisv;
    irq_vec_t irr;       // Pending and enabled
    irq_num_t win_num;   // Best request
    irq_vec_t win_hot;
    irq_vec_t cur_hot;   // Current vector as a bit
    irq_vec_t isvr_eoi;  // In service once current retires
    irq_num_t eoi_num;   // Fallback vector

    // --------------------
    // Priority search
    // --------------------
    assign irr      = ipr & cfg.ie;
    assign win_num  = find_lowest(irr);
    assign isvr_eoi = isvr & ~cur_hot;
    assign eoi_num  = find_lowest(isvr_eoi);

    always_comb begin
        for (int i = 0; i < `IPIC_LINES; i++) begin
            win_hot[i] = (win_num == irq_num_t'(i));
            cur_hot[i] = (cisv == irq_num_t'(i)); // All zero when void
        end
    end

    // Only a strictly higher priority preempts
    assign irq_req = (win_num != VOID) && (~|isvr || (win_num < cisv));
    assign taken   = (ctl.soi && irq_req) ? win_hot : '0;

    // --------------------
    // In-service state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr <= '0;
            cisv <= VOID;
        end else if (ctl.soi && irq_req) begin
            isvr <= isvr | win_hot;
            cisv <= win_num;
        end else if (ctl.eoi && (cisv != VOID)) begin
            isvr <= isvr_eoi;
            cisv <= eoi_num; // Next lower line in service, or void
        end
    end

    assign svc = '{isvr: isvr, cisv: cisv};

endmodule

/* hw/ipic_top.sv */
/*
 * Programmable interrupt controller, eight lines
 * APB register side, pending logic and service tracking
 */

`timescale 1ns/1ps

module ipic_top
    import ipic_reg_pkg::*;
    import ipic_irq_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  irq_vec_t  irq_lines,
    // APB slave
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    // To the core
    output logic      irq_req
);

    ipic_cfg_t cfg;   // Line configuration
    ipic_ctl_t ctl;   // Write strobes
    irq_vec_t  ipr;   // Pending vector
    ipic_svc_t svc;   // Service state
    irq_vec_t  taken; // SOI clear of the winner

    ipic_apb_regs i_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .ipr     (ipr),
        .svc     (svc),
        .cfg     (cfg),
        .ctl     (ctl)
    );

    ipic_pending i_pending (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_lines (irq_lines),
        .cfg       (cfg),
        .ctl       (ctl),
        .taken     (taken),
        .ipr       (ipr)
    );

    ipic_service i_service (
        .clk     (clk),
        .rst_n   (rst_n),
        .ipr     (ipr),
        .cfg     (cfg),
        .ctl     (ctl),
        .svc     (svc),
        .taken   (taken),
        .irq_req (irq_req)
    );

endmodule

/* ipic_top.f */
+incdir+hw
hw/ipic_reg_pkg.sv
hw/ipic_irq_pkg.sv
hw/ipic_apb_regs.sv
hw/ipic_pending.sv
hw/ipic_service.sv
hw/ipic_top.sv
test/ipic_tb.sv

/* test/ipic_tb.sv */
/*
 * Testbench of the interrupt controller
 * Table of APB, line and irq_req steps applied in a loop
 */

`timescale 1ns/1ps

`include "ipic_consts.svh"

module ipic_tb;

    typedef enum logic [2:0] {OP_LINES, OP_WRITE, OP_READ, OP_IRQ, OP_IDLE} op_e;

    // One table row
    typedef struct packed {
        op_e         op;
        logic [4:0]  addr;
        logic [31:0] data;     // Write data or line levels
        logic [31:0] exp_val;  // prdata or irq_req
        int          test;
    } step_t;

    // Register byte addresses
    localparam logic [4:0] A_CISV = 5'h00;
    localparam logic [4:0] A_IPR  = 5'h08;
    localparam logic [4:0] A_ISVR = 5'h0C;
    localparam logic [4:0] A_EOI  = 5'h10;
    localparam logic [4:0] A_SOI  = 5'h14;
    localparam logic [4:0] A_IDX  = 5'h18;
    localparam logic [4:0] A_ICSR = 5'h1C;

    // ICSR bits 3:1 per line as INV IM IE
    localparam logic [3:0] LINE_CFG [`IPIC_LINES] = '{
        4'h2, 4'h4, 4'h6, 4'h8, 4'hA, 4'hC, 4'hE, 4'h0
    };

    logic        clk;
    logic        rst_n;
    logic [7:0]  irq_lines;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        irq_req;

    step_t steps[$];
    int    n_checks = 0;
    int    n_errors = 0;
    int    test_checks = 0;
    int    test_errors = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000;  // Replaced once the table is built

    ipic_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------
    // Stimulus table
    // --------------------
    function automatic void add_step(input op_e op, input logic [4:0] addr,
                                     input logic [31:0] data, input logic [31:0] exp_val,
                                     input int test);
        step_t s;
        s = '{op: op, addr: addr, data: data, exp_val: exp_val, test: test};
        steps.push_back(s);
    endfunction

    // IDX write followed by ICSR write of that line
    task automatic config_line(input int line, input logic [3:0] bits, input int test);
        logic [31:0] wr;
        wr = $urandom;          // Upper bits read-only or unused
        wr[3:0] = bits & 4'hE;  // IP kept 0 so nothing clears
        add_step(OP_WRITE, A_IDX, 32'(line), 32'h0, test);
        add_step(OP_WRITE, A_ICSR, wr, 32'h0, test);
    endtask

    task automatic build_table();
        int          order[`IPIC_LINES];
        int          j;
        int          ln;
        logic [3:0]  c;
        logic [31:0] exp_v;
        logic [7:0]  isvr_model;
        add_step(OP_IDLE, A_CISV, 32'h0, 32'h0, 1);   // Reset state
        add_step(OP_READ, A_CISV, 32'h0, 32'h8, 1);
        add_step(OP_READ, A_IPR, 32'h0, 32'h0, 1);
        add_step(OP_READ, A_ISVR, 32'h0, 32'h0, 1);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h0, 1);
        config_line(3, 4'hA, 2);                      // Level mode inverted with the line low
        add_step(OP_READ, A_IPR, 32'h0, 32'h08, 2);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h1, 2);
        add_step(OP_WRITE, A_IPR, 32'h08, 32'h0, 2);  // Active level holds it
        add_step(OP_READ, A_IPR, 32'h0, 32'h08, 2);
        add_step(OP_LINES, A_CISV, 32'h08, 32'h0, 2);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h0, 2);
        config_line(5, 4'h6, 3);                      // Edge mode enabled
        add_step(OP_LINES, A_CISV, 32'h28, 32'h0, 3); // One cycle pulse
        add_step(OP_LINES, A_CISV, 32'h08, 32'h0, 3);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h1, 3);
        add_step(OP_READ, A_IPR, 32'h0, 32'h20, 3);
        add_step(OP_WRITE, A_IPR, 32'h20, 32'h0, 3);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h0, 3);
        config_line(2, 4'h6, 4);
        config_line(6, 4'h6, 4);
        add_step(OP_LINES, A_CISV, 32'h4C, 32'h0, 4);
        add_step(OP_LINES, A_CISV, 32'h08, 32'h0, 4);
        add_step(OP_READ, A_IPR, 32'h0, 32'h44, 4);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h1, 4);
        add_step(OP_WRITE, A_SOI, $urandom, 32'h0, 4); // Line 2 wins
        add_step(OP_READ, A_CISV, 32'h0, 32'h2, 4);
        add_step(OP_READ, A_ISVR, 32'h0, 32'h04, 4);
        add_step(OP_READ, A_IPR, 32'h0, 32'h40, 4);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h0, 4);    // 6 does not beat 2
        add_step(OP_WRITE, A_EOI, $urandom, 32'h0, 5);
        add_step(OP_READ, A_CISV, 32'h0, 32'h8, 5);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h1, 5);
        add_step(OP_WRITE, A_SOI, $urandom, 32'h0, 5); // Line 6 in service
        add_step(OP_READ, A_CISV, 32'h0, 32'h6, 5);
        config_line(1, 4'h6, 5);
        add_step(OP_LINES, A_CISV, 32'h0A, 32'h0, 5);
        add_step(OP_IRQ, A_CISV, 32'h0, 32'h1, 5);    // 1 preempts 6
        add_step(OP_WRITE, A_SOI, $urandom, 32'h0, 5);
        add_step(OP_READ, A_CISV, 32'h0, 32'h1, 5);
        add_step(OP_READ, A_ISVR, 32'h0, 32'h42, 5);
        add_step(OP_WRITE, A_EOI, $urandom, 32'h0, 5);
        add_step(OP_READ, A_CISV, 32'h0, 32'h6, 5);   // Back to line 6
        add_step(OP_WRITE, A_EOI, $urandom, 32'h0, 5);
        add_step(OP_READ, A_CISV, 32'h0, 32'h8, 5);
        add_step(OP_READ, A_ISVR, 32'h0, 32'h0, 5);
        add_step(OP_LINES, A_CISV, 32'h00, 32'h0, 6); // All lines low
        config_line(3, 4'h0, 6);
        add_step(OP_LINES, A_CISV, 32'h20, 32'h0, 6); // Edge on line 5
        add_step(OP_LINES, A_CISV, 32'h00, 32'h0, 6);
        add_step(OP_WRITE, A_SOI, $urandom, 32'h0, 6); // Line 5 into service
        add_step(OP_READ, A_ISVR, 32'h0, 32'h20, 6);
        add_step(OP_WRITE, A_IPR, 32'hFF, 32'h0, 6);  // Drop held edges
        add_step(OP_READ, A_IPR, 32'h0, 32'h0, 6);
        isvr_model = 8'h20;  // Line 5 stays in service
        for (int i = 0; i < `IPIC_LINES; i++) begin
            order[i] = i;
        end
        for (int i = `IPIC_LINES - 1; i > 0; i--) begin
            j = int'($urandom % (i + 1));
            ln = order[j];
            order[j] = order[i];
            order[i] = ln;
        end
        foreach (order[k]) begin
            ln = order[k];
            c = LINE_CFG[ln];
            exp_v = '0;
            exp_v[3:1] = c[3:1];
            // Level line with low input is pending exactly when inverted
            exp_v[`IPIC_ICSR_IP] = c[`IPIC_ICSR_INV] & ~c[`IPIC_ICSR_IM];
            exp_v[`IPIC_ICSR_IS] = isvr_model[ln];
            exp_v[`IPIC_ICSR_LN_LSB +: 3] = 3'(ln);
            config_line(ln, c, 6);
            add_step(OP_READ, A_ICSR, 32'h0, exp_v, 6);
        end
    endtask

    // --------------------
    // Bus and check tasks
    // --------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        next_cycle();
        psel   = 1'b1;  // Setup phase
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #2 penable = 1'b1;  // Access phase commits at the next edge
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
        next_cycle();
        psel  = 1'b1;
        paddr = addr;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);  // prdata settled mid access
        data = prdata;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] got);
        n_checks++;
        test_checks++;
        assert (got === exp_v) else begin
            $display("mismatch at %0t: %s expected 0x%08h, got 0x%08h", $time, what, exp_v, got);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int test);
        $display("test %0d done: %0d checks, %0d errors", test, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // --------------------
    // Run
    // --------------------
    initial begin
        step_t       s;
        logic [31:0] rd;
        int          cur_test;
        void'($urandom(32'h68b0));
        rst_n     = 1'b0;
        irq_lines = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        build_table();
        cycle_limit = 3 * steps.size() + 50;
        cur_test = 1;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        foreach (steps[k]) begin
            s = steps[k];
            if (s.test != cur_test) begin
                report_test(cur_test);
                cur_test = s.test;
            end
            case (s.op)
                OP_LINES: begin
                    next_cycle();
                    irq_lines = s.data[`IPIC_LINES-1:0];
                end
                OP_WRITE: apb_write(s.addr, s.data);
                OP_READ: begin
                    apb_read(s.addr, rd);
                    check_value($sformatf("read of 0x%02h", s.addr), s.exp_val, rd);
                end
                OP_IRQ: begin
                    next_cycle();
                    @(negedge clk);  // One cycle after the last change
                    check_value("irq_req", s.exp_val, {31'b0, irq_req});
                end
                default: next_cycle();
            endcase
        end
        report_test(cur_test);
        $display("Totals: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
